//--- design/exec_pkg.sv
// Shared widths, CSR addresses and enums, imported by every module of the execute stage
package exec_pkg;

    ////////////////////////////////////////////////////////////
    // Widths
    ////////////////////////////////////////////////////////////

    // Data path width
    localparam int XLEN = 32;

    // One write strobe per byte lane
    localparam int STRB_W = XLEN / 8;

    // Retirement tag carried alongside each instruction
    localparam int TAG_W = 3;

    localparam int CSR_ADDR_W = 12;

    ////////////////////////////////////////////////////////////
    // CSR map
    ////////////////////////////////////////////////////////////

    localparam logic [CSR_ADDR_W-1:0] CSR_MSCRATCH = 12'h340;
    localparam logic [CSR_ADDR_W-1:0] CSR_MEPC     = 12'h341;
    localparam logic [CSR_ADDR_W-1:0] CSR_MTVEC    = 12'h305;
    localparam logic [CSR_ADDR_W-1:0] CSR_MHARTID  = 12'hF14;

    // Address bits 11:10 equal to this mark a read-only CSR
    localparam logic [1:0] CSR_RO_PREFIX = 2'b11;

    // Value returned by mhartid
    localparam logic [XLEN-1:0] HART_ID = 32'h0000_0001;

    // Link address step for JAL and JALR
    localparam logic [XLEN-1:0] LINK_OFFSET = 32'd4;

    ////////////////////////////////////////////////////////////
    // Enums
    ////////////////////////////////////////////////////////////

    // Decoded operation from the decode stage
    typedef enum logic [5:0] {
        NOP,
        // Register and immediate arithmetic
        ADD, SUB, SLT, SLTU, XOR, OR, AND,
        // Shifts
        SLL, SRL, SRA,
        // Upper immediates
        LUI, AUIPC,
        // Jumps and branches
        JAL, JALR,
        BEQ, BNE, BLT, BLTU, BGE, BGEU,
        // Loads
        LB, LBU, LH, LHU, LW,
        // Stores
        SB, SH, SW,
        // CSR access, register and immediate source
        CSRRW, CSRRS, CSRRC,
        CSRRWI, CSRRSI, CSRRCI
    } op_e;

    // Update rule applied by the CSR bank
    typedef enum logic [1:0] {
        CSR_NONE,
        CSR_WRITE,
        CSR_SET,
        CSR_CLEAR
    } csr_op_e;

    // Privilege level, encoded as in the CSR address bits 9:8
    typedef enum logic [1:0] {
        PRIV_U = 2'd0,
        PRIV_S = 2'd1,
        PRIV_M = 2'd3
    } priv_e;

endpackage

//--- design/exec_unit.sv
// Execute datapath of the stage: ALU, branch decision, memory formatting, CSR requests, retire register
`timescale 1ns/10ps

module exec_unit
    import exec_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n_i,
    input  logic                  stall_i,

    // From decode
    input  logic [XLEN-1:0]       instruction_i,
    input  logic [XLEN-1:0]       pc_i,
    input  logic [XLEN-1:0]       operand_a_i,
    input  logic [XLEN-1:0]       operand_b_i,
    input  logic [XLEN-1:0]       operand_c_i,
    input  op_e                   op_i,
    input  logic [TAG_W-1:0]      tag_i,
    input  priv_e                 priv_i,
    input  logic                  exc_illegal_i,
    input  logic                  exc_misaligned_i,

    // CSR bank
    input  logic [XLEN-1:0]       csr_rdata_i,
    output logic                  csr_read_en_o,
    output logic                  csr_write_en_o,
    output csr_op_e               csr_op_o,
    output logic [CSR_ADDR_W-1:0] csr_addr_o,
    output logic [XLEN-1:0]       csr_wdata_o,

    // Data memory
    output logic                  mem_read_en_o,
    output logic [STRB_W-1:0]     mem_write_en_o,
    output logic [XLEN-1:0]       mem_addr_o,
    output logic [XLEN-1:0]       mem_write_data_o,

    // To retire
    output logic [XLEN-1:0]       instruction_o,
    output logic [XLEN-1:0]       pc_o,
    output op_e                   op_o,
    output logic [XLEN-1:0]       result_o,
    output logic [XLEN-1:0]       target_o,
    output logic [TAG_W-1:0]      tag_o,
    output logic                  jump_o,
    output logic                  write_en_o,
    output logic                  exc_illegal_o,
    output logic                  exc_misaligned_o
);

    ////////////////////////////////////////////////////////////
    // ALU
    ////////////////////////////////////////////////////////////

    logic [XLEN-1:0] sum_ab;
    logic [XLEN-1:0] sum2_a;
    logic [XLEN-1:0] sum2_b;
    logic [XLEN-1:0] sum2;
    logic [XLEN-1:0] and_res;
    logic [XLEN-1:0] or_res;
    logic [XLEN-1:0] xor_res;
    logic [XLEN-1:0] sll_res;
    logic [XLEN-1:0] srl_res;
    logic [XLEN-1:0] sra_res;
    logic [4:0]      shamt;
    logic            eq;
    logic            lt;
    logic            ltu;
    logic            jump;

    // Second adder serves SUB, AUIPC, the link address and the branch target
    always_comb begin
        sum2_a = (op_i == SUB) ? operand_a_i : pc_i;
        case (op_i)
            JAL, JALR: sum2_b = LINK_OFFSET;
            SUB:       sum2_b = ~operand_b_i + 1'b1;
            default:   sum2_b = operand_c_i;
        endcase
    end

    assign shamt   = operand_b_i[4:0];
    assign sum_ab  = operand_a_i + operand_b_i;
    assign sum2    = sum2_a + sum2_b;
    assign and_res = operand_a_i & operand_b_i;
    assign or_res  = operand_a_i | operand_b_i;
    assign xor_res = operand_a_i ^ operand_b_i;
    assign sll_res = operand_a_i << shamt;
    assign srl_res = operand_a_i >> shamt;
    assign sra_res = $signed(operand_a_i) >>> shamt;

    assign eq  = (operand_a_i == operand_b_i);
    assign lt  = ($signed(operand_a_i) < $signed(operand_b_i));
    assign ltu = (operand_a_i < operand_b_i);

    // Greater-or-equal is the inverse of less-than
    always_comb begin
        case (op_i)
            BEQ:       jump = eq;
            BNE:       jump = ~eq;
            BLT:       jump = lt;
            BLTU:      jump = ltu;
            BGE:       jump = ~lt;
            BGEU:      jump = ~ltu;
            JAL, JALR: jump = 1'b1;
            default:   jump = 1'b0;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Load and store
    ////////////////////////////////////////////////////////////

    assign mem_addr_o    = {sum_ab[XLEN-1:2], 2'b00};
    assign mem_read_en_o = op_i inside {LB, LBU, LH, LHU, LW};

    // Lanes picked from the low address bits
    always_comb begin
        case (op_i)
            SB: begin
                case (sum_ab[1:0])
                    2'b00:   mem_write_en_o = 4'b0001;
                    2'b01:   mem_write_en_o = 4'b0010;
                    2'b10:   mem_write_en_o = 4'b0100;
                    default: mem_write_en_o = 4'b1000;
                endcase
            end
            SH:      mem_write_en_o = sum_ab[1] ? 4'b1100 : 4'b0011;
            SW:      mem_write_en_o = 4'b1111;
            default: mem_write_en_o = '0;
        endcase
    end

    always_comb begin
        case (op_i)
            SB:      mem_write_data_o = {4{operand_c_i[7:0]}};
            SH:      mem_write_data_o = {2{operand_c_i[15:0]}};
            default: mem_write_data_o = operand_c_i;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // CSR request
    ////////////////////////////////////////////////////////////

    logic [4:0] rd;
    logic [4:0] rs1;
    logic       csr_rd_req;
    logic       csr_wr_req;
    logic       csr_illegal;

    assign rd         = instruction_i[11:7];
    assign rs1        = instruction_i[19:15];
    assign csr_addr_o = instruction_i[31:20];

    // No read for a swap into x0, no write for a set or clear from x0
    always_comb begin
        case (op_i)
            CSRRW, CSRRWI: begin
                csr_rd_req = (rd != '0);
                csr_wr_req = 1'b1;
            end
            CSRRS, CSRRC, CSRRSI, CSRRCI: begin
                csr_rd_req = 1'b1;
                csr_wr_req = (rs1 != '0);
            end
            default: begin
                csr_rd_req = 1'b0;
                csr_wr_req = 1'b0;
            end
        endcase
    end

    always_comb begin
        case (op_i)
            CSRRW, CSRRWI: csr_op_o = CSR_WRITE;
            CSRRS, CSRRSI: csr_op_o = CSR_SET;
            CSRRC, CSRRCI: csr_op_o = CSR_CLEAR;
            default:       csr_op_o = CSR_NONE;
        endcase
    end

    // Immediate forms carry the zero-extended rs1 field
    assign csr_wdata_o = (op_i inside {CSRRW, CSRRS, CSRRC}) ? operand_a_i
                                                             : {{(XLEN-5){1'b0}}, rs1};

    // Read-only write, or address privilege above the current level
    assign csr_illegal = (csr_wr_req && csr_addr_o[11:10] == CSR_RO_PREFIX)
                       || ((csr_rd_req || csr_wr_req) && csr_addr_o[9:8] > priv_i);

    assign csr_read_en_o  = csr_rd_req & ~csr_illegal;
    assign csr_write_en_o = csr_wr_req & ~csr_illegal;

    ////////////////////////////////////////////////////////////
    // Result select
    ////////////////////////////////////////////////////////////

    logic [XLEN-1:0] result;
    logic [XLEN-1:0] target;
    logic            write_en;

    always_comb begin
        case (op_i)
            CSRRW, CSRRS, CSRRC,
            CSRRWI, CSRRSI, CSRRCI:  result = csr_rdata_i;
            SUB, AUIPC, JAL, JALR:   result = sum2;
            SLT:                     result = {{(XLEN-1){1'b0}}, lt};
            SLTU:                    result = {{(XLEN-1){1'b0}}, ltu};
            XOR:                     result = xor_res;
            OR:                      result = or_res;
            AND:                     result = and_res;
            SLL:                     result = sll_res;
            SRL:                     result = srl_res;
            SRA:                     result = sra_res;
            LUI:                     result = operand_b_i;
            default:                 result = sum_ab;
        endcase
    end

    // Jump targets from the first adder, branch target from the second
    always_comb begin
        case (op_i)
            JALR:    target = {sum_ab[XLEN-1:1], 1'b0};
            JAL:     target = sum_ab;
            default: target = sum2;
        endcase
    end

    assign write_en = !(op_i inside {SB, SH, SW, BEQ, BNE, BLT, BLTU, BGE, BGEU});

    ////////////////////////////////////////////////////////////
    // Retire register
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            instruction_o    <= '0;
            pc_o             <= '0;
            op_o             <= NOP;
            result_o         <= '0;
            target_o         <= '0;
            tag_o            <= '0;
            jump_o           <= 1'b0;
            write_en_o       <= 1'b0;
            exc_illegal_o    <= 1'b0;
            exc_misaligned_o <= 1'b0;
        end else if (!stall_i) begin
            instruction_o    <= instruction_i;
            pc_o             <= pc_i;
            op_o             <= op_i;
            result_o         <= result;
            target_o         <= target;
            tag_o            <= tag_i;
            jump_o           <= jump;
            write_en_o       <= write_en;
            // Decode exception merged with the CSR access check
            exc_illegal_o    <= exc_illegal_i | csr_illegal;
            exc_misaligned_o <= exc_misaligned_i;
        end
    end

endmodule

//--- design/csr_bank.sv
// Machine-mode CSR bank, read combinationally and updated on the edge that loads the retire register
`timescale 1ns/10ps

module csr_bank
    import exec_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n_i,
    input  logic                  stall_i,

    // Access request from the execute unit, already checked
    input  logic                  csr_read_en_i,
    input  logic                  csr_write_en_i,
    input  csr_op_e               csr_op_i,
    input  logic [CSR_ADDR_W-1:0] csr_addr_i,
    input  logic [XLEN-1:0]       csr_wdata_i,

    output logic [XLEN-1:0]       csr_rdata_o
);

    ////////////////////////////////////////////////////////////
    // Storage
    ////////////////////////////////////////////////////////////

    logic [XLEN-1:0] mscratch_q;
    logic [XLEN-1:0] mepc_q;
    logic [XLEN-1:0] mtvec_q;

    // Current value at the addressed CSR
    logic [XLEN-1:0] cur_val;

    // Value after the write, set or clear
    logic [XLEN-1:0] new_val;

    logic            update;

    ////////////////////////////////////////////////////////////
    // Read
    ////////////////////////////////////////////////////////////

    // Unknown addresses read as zero
    always_comb begin
        case (csr_addr_i)
            CSR_MSCRATCH: cur_val = mscratch_q;
            CSR_MEPC:     cur_val = mepc_q;
            CSR_MTVEC:    cur_val = mtvec_q;
            CSR_MHARTID:  cur_val = HART_ID;
            default:      cur_val = '0;
        endcase
    end

    // Old value goes out even when the same access writes
    assign csr_rdata_o = csr_read_en_i ? cur_val : '0;

    ////////////////////////////////////////////////////////////
    // Update
    ////////////////////////////////////////////////////////////

    always_comb begin
        case (csr_op_i)
            CSR_WRITE: new_val = csr_wdata_i;
            CSR_SET:   new_val = cur_val | csr_wdata_i;
            CSR_CLEAR: new_val = cur_val & ~csr_wdata_i;
            default:   new_val = cur_val;
        endcase
    end

    // Stall freezes the bank together with the retire register
    assign update = csr_write_en_i & ~stall_i;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            mscratch_q <= '0;
            mepc_q     <= '0;
            mtvec_q    <= '0;
        end else if (update) begin
            case (csr_addr_i)
                CSR_MSCRATCH: mscratch_q <= new_val;
                CSR_MEPC:     mepc_q     <= new_val;
                CSR_MTVEC:    mtvec_q    <= new_val;
                // mhartid is constant, unknown addresses are dropped
                default: ;
            endcase
        end
    end

endmodule

//--- design/exec_stage_top.sv
// Execute stage top level, joining the execute unit with the machine CSR bank it steers
`timescale 1ns/10ps

module exec_stage_top
    import exec_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n_i,
    input  logic                  stall_i,

    input  logic [XLEN-1:0]       instruction_i,
    input  logic [XLEN-1:0]       pc_i,
    input  logic [XLEN-1:0]       operand_a_i,
    input  logic [XLEN-1:0]       operand_b_i,
    input  logic [XLEN-1:0]       operand_c_i,
    input  op_e                   op_i,
    input  logic [TAG_W-1:0]      tag_i,
    input  priv_e                 priv_i,
    input  logic                  exc_illegal_i,
    input  logic                  exc_misaligned_i,

    // Data memory, same cycle
    output logic                  mem_read_en_o,
    output logic [STRB_W-1:0]     mem_write_en_o,
    output logic [XLEN-1:0]       mem_addr_o,
    output logic [XLEN-1:0]       mem_write_data_o,

    // Retirement, one cycle later
    output logic [XLEN-1:0]       instruction_o,
    output logic [XLEN-1:0]       pc_o,
    output op_e                   op_o,
    output logic [XLEN-1:0]       result_o,
    output logic [XLEN-1:0]       target_o,
    output logic [TAG_W-1:0]      tag_o,
    output logic                  jump_o,
    output logic                  write_en_o,
    output logic                  exc_illegal_o,
    output logic                  exc_misaligned_o
);

    ////////////////////////////////////////////////////////////
    // CSR path between unit and bank
    ////////////////////////////////////////////////////////////

    logic                  csr_read_en;
    logic                  csr_write_en;
    csr_op_e               csr_op;
    logic [CSR_ADDR_W-1:0] csr_addr;
    logic [XLEN-1:0]       csr_wdata;
    logic [XLEN-1:0]       csr_rdata;

    // Stage ports share their names with the unit
    exec_unit i_exec_unit (
        .csr_rdata_i    (csr_rdata),
        .csr_read_en_o  (csr_read_en),
        .csr_write_en_o (csr_write_en),
        .csr_op_o       (csr_op),
        .csr_addr_o     (csr_addr),
        .csr_wdata_o    (csr_wdata),
        .*
    );

    csr_bank i_csr_bank (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .stall_i        (stall_i),
        .csr_read_en_i  (csr_read_en),
        .csr_write_en_i (csr_write_en),
        .csr_op_i       (csr_op),
        .csr_addr_i     (csr_addr),
        .csr_wdata_i    (csr_wdata),
        .csr_rdata_o    (csr_rdata)
    );

endmodule

//--- tb/exec_clk_gen.sv
// Free-running testbench clock for the execute stage, 4 ns period
`timescale 1ns/10ps

module exec_clk_gen (
    output logic clk
);

    initial begin
        clk = 1'b0;
    end

    always #2 clk = ~clk;

endmodule

//--- tb/exec_stage_assertions.sv
// Concurrent checks on the retire register of the execute unit, attached to exec_unit by bind
`timescale 1ns/10ps

module exec_stage_assertions
    import exec_pkg::*;
(
    input logic             clk,
    input logic             rst_n_i,
    input logic             stall_i,
    input op_e              op_i,
    input logic [XLEN-1:0]  instruction_o,
    input logic [XLEN-1:0]  pc_o,
    input op_e              op_o,
    input logic [XLEN-1:0]  result_o,
    input logic [XLEN-1:0]  target_o,
    input logic [TAG_W-1:0] tag_o,
    input logic             jump_o,
    input logic             write_en_o,
    input logic             exc_illegal_o,
    input logic             exc_misaligned_o
);

    // Stalled edge keeps every retire field
    hold_on_stall: assert property (@(posedge clk) disable iff (!rst_n_i)
        stall_i |=> ($stable(result_o) && $stable(target_o) && $stable(pc_o)
                     && $stable(instruction_o) && $stable(op_o) && $stable(tag_o)
                     && $stable(jump_o) && $stable(write_en_o) && $stable(exc_illegal_o)
                     && $stable(exc_misaligned_o)))
        else $error("retire register changed during stall");

    no_write_store_branch: assert property (@(posedge clk) disable iff (!rst_n_i)
        (!stall_i && (op_i inside {SB, SH, SW, BEQ, BNE, BLT, BLTU, BGE, BGEU})) |=> !write_en_o)
        else $error("write enable set after store or branch");

    jump_after_jal: assert property (@(posedge clk) disable iff (!rst_n_i)
        (!stall_i && (op_i inside {JAL, JALR})) |=> jump_o)
        else $error("jump missing after JAL or JALR");

endmodule

//--- tb/exec_stage_tb.sv
// Testbench for the execute stage, replays tb/exec_stim.txt and checks memory and retire outputs
`timescale 1ns/10ps

module exec_stage_tb
    import exec_pkg::*;
;

    localparam int MAX_VEC = 128;
    localparam int N_FIELD = 19;

    // Column positions in the stimulus file
    localparam int F_STALL = 0;
    localparam int F_OP    = 1;
    localparam int F_INSTR = 2;
    localparam int F_PC    = 3;
    localparam int F_A     = 4;
    localparam int F_B     = 5;
    localparam int F_C     = 6;
    localparam int F_PRIV  = 7;
    localparam int F_EILL  = 8;
    localparam int F_EMIS  = 9;
    localparam int F_RES   = 10;
    localparam int F_TGT   = 11;
    localparam int F_JMP   = 12;
    localparam int F_WE    = 13;
    localparam int F_RDEN  = 14;
    localparam int F_STRB  = 15;
    localparam int F_ADDR  = 16;
    localparam int F_ILL   = 17;
    localparam int F_WDATA = 18;

    logic clk;
    logic rst_n_i;
    logic stall_i;
    logic [XLEN-1:0] instruction_i;
    logic [XLEN-1:0] pc_i;
    logic [XLEN-1:0] operand_a_i;
    logic [XLEN-1:0] operand_b_i;
    logic [XLEN-1:0] operand_c_i;
    op_e op_i;
    logic [TAG_W-1:0] tag_i;
    priv_e priv_i;
    logic exc_illegal_i;
    logic exc_misaligned_i;
    logic mem_read_en_o;
    logic [STRB_W-1:0] mem_write_en_o;
    logic [XLEN-1:0] mem_addr_o;
    logic [XLEN-1:0] mem_write_data_o;
    logic [XLEN-1:0] instruction_o;
    logic [XLEN-1:0] pc_o;
    op_e op_o;
    logic [XLEN-1:0] result_o;
    logic [XLEN-1:0] target_o;
    logic [TAG_W-1:0] tag_o;
    logic jump_o;
    logic write_en_o;
    logic exc_illegal_o;
    logic exc_misaligned_o;

    logic [31:0] vec_mem [0:MAX_VEC-1][0:N_FIELD-1];
    int          n_vec;
    logic        loaded;

    // Expected retire state, follows every unstalled vector
    logic [XLEN-1:0]  exp_instr;
    logic [XLEN-1:0]  exp_pc;
    op_e              exp_op;
    logic [XLEN-1:0]  exp_res;
    logic [XLEN-1:0]  exp_tgt;
    logic [TAG_W-1:0] exp_tag;
    logic             exp_jmp;
    logic             exp_we;
    logic             exp_ill;
    logic             exp_mis;

    exec_clk_gen i_clk_gen (.clk(clk));

    exec_stage_top i_dut (.*);

    bind exec_unit exec_stage_assertions i_assertions (.*);

    ////////////////////////////////////////////////////////////
    // Compare tasks
    ////////////////////////////////////////////////////////////

    task automatic check_word(input string name, input logic [XLEN-1:0] exp,
                              input logic [XLEN-1:0] act);
        if (act !== exp) begin
            $display("** Error at %0t ns: %s expected %h, got %h", $time, name, exp, act);
            $display("Test failed");
            $fatal(1);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("** Error at %0t ns: %s expected %b, got %b", $time, name, exp, act);
            $display("Test failed");
            $fatal(1);
        end
    endtask

    task automatic check_op(input string name, input op_e exp, input op_e act);
        if (act !== exp) begin
            $display("** Error at %0t ns: %s expected %s, got %s", $time, name,
                     exp.name(), act.name());
            $display("Test failed");
            $fatal(1);
        end
    endtask

    task automatic check_strobe(input string name, input logic [STRB_W-1:0] exp,
                                input logic [STRB_W-1:0] act);
        if (act !== exp) begin
            $display("** Error at %0t ns: %s expected %b, got %b", $time, name, exp, act);
            $display("Test failed");
            $fatal(1);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Stimulus file
    ////////////////////////////////////////////////////////////

    task automatic load_vectors();
        int          fd;
        int          cnt;
        string       line;
        logic [31:0] f [0:N_FIELD-1];
        fd = $fopen("tb/exec_stim.txt", "r");
        if (fd == 0) begin
            $display("Could not open the stimulus file tb/exec_stim.txt");
            $display("Test failed");
            $fatal(1);
        end
        while (!$feof(fd) && n_vec < MAX_VEC) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() > 1 && line[0] != "#") begin
                cnt = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                              f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9],
                              f[10], f[11], f[12], f[13], f[14], f[15], f[16], f[17], f[18]);
                if (cnt == N_FIELD) begin
                    for (int k = 0; k < N_FIELD; k++) begin
                        vec_mem[n_vec][k] = f[k];
                    end
                    n_vec++;
                end
            end
        end
        $fclose(fd);
    endtask

    task automatic drive_vector(input int i);
        stall_i          <= vec_mem[i][F_STALL][0];
        op_i             <= op_e'(vec_mem[i][F_OP][5:0]);
        instruction_i    <= vec_mem[i][F_INSTR];
        pc_i             <= vec_mem[i][F_PC];
        operand_a_i      <= vec_mem[i][F_A];
        operand_b_i      <= vec_mem[i][F_B];
        operand_c_i      <= vec_mem[i][F_C];
        priv_i           <= priv_e'(vec_mem[i][F_PRIV][1:0]);
        exc_illegal_i    <= vec_mem[i][F_EILL][0];
        exc_misaligned_i <= vec_mem[i][F_EMIS][0];
        tag_i            <= i[TAG_W-1:0];
    endtask

    task automatic check_memory(input int i);
        check_bit("mem_read_en_o", vec_mem[i][F_RDEN][0], mem_read_en_o);
        check_strobe("mem_write_en_o", vec_mem[i][F_STRB][STRB_W-1:0], mem_write_en_o);
        check_word("mem_addr_o", vec_mem[i][F_ADDR], mem_addr_o);
        check_word("mem_write_data_o", vec_mem[i][F_WDATA], mem_write_data_o);
    endtask

    task automatic check_retire();
        check_word("instruction_o", exp_instr, instruction_o);
        check_word("pc_o", exp_pc, pc_o);
        check_op("op_o", exp_op, op_o);
        check_word("result_o", exp_res, result_o);
        check_word("target_o", exp_tgt, target_o);
        check_word("tag_o", {{(XLEN-TAG_W){1'b0}}, exp_tag}, {{(XLEN-TAG_W){1'b0}}, tag_o});
        check_bit("jump_o", exp_jmp, jump_o);
        check_bit("write_en_o", exp_we, write_en_o);
        check_bit("exc_illegal_o", exp_ill, exc_illegal_o);
        check_bit("exc_misaligned_o", exp_mis, exc_misaligned_o);
    endtask

    // Next expected retire state after vector i is captured
    task automatic capture_expected(input int i);
        exp_instr = vec_mem[i][F_INSTR];
        exp_pc    = vec_mem[i][F_PC];
        exp_op    = op_e'(vec_mem[i][F_OP][5:0]);
        exp_res   = vec_mem[i][F_RES];
        exp_tgt   = vec_mem[i][F_TGT];
        exp_tag   = i[TAG_W-1:0];
        exp_jmp   = vec_mem[i][F_JMP][0];
        exp_we    = vec_mem[i][F_WE][0];
        exp_ill   = vec_mem[i][F_ILL][0];
        exp_mis   = vec_mem[i][F_EMIS][0];
    endtask

    ////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////

    initial begin
        rst_n_i          = 1'b0;
        stall_i          = 1'b0;
        instruction_i    = '0;
        pc_i             = '0;
        operand_a_i      = '0;
        operand_b_i      = '0;
        operand_c_i      = '0;
        op_i             = NOP;
        tag_i            = '0;
        priv_i           = PRIV_M;
        exc_illegal_i    = 1'b0;
        exc_misaligned_i = 1'b0;
        n_vec            = 0;
        loaded           = 1'b0;
        // Reset state of the retire register
        exp_instr = '0;
        exp_pc    = '0;
        exp_op    = NOP;
        exp_res   = '0;
        exp_tgt   = '0;
        exp_tag   = '0;
        exp_jmp   = 1'b0;
        exp_we    = 1'b0;
        exp_ill   = 1'b0;
        exp_mis   = 1'b0;

        load_vectors();
        loaded = 1'b1;

        repeat (4) @(posedge clk);
        rst_n_i <= 1'b1;

        // First vector goes out on the edge that releases reset
        // One extra idle cycle lets the last vector retire
        for (int i = 0; i <= n_vec; i++) begin
            if (i < n_vec) begin
                drive_vector(i);
            end else begin
                stall_i <= 1'b0;
                op_i    <= NOP;
            end
            @(negedge clk);
            check_retire();
            if (i < n_vec) begin
                check_memory(i);
                if (!vec_mem[i][F_STALL][0]) begin
                    capture_expected(i);
                end
            end
            @(posedge clk);
        end

        $display("Test completed successfully");
        $finish;
    end

    // Watchdog sized from the vector count
    initial begin
        wait (loaded);
        #((n_vec + 20) * 4);
        $display("Watchdog expired before all vectors were applied");
        $display("Test failed");
        $fatal(1);
    end

endmodule

//--- tb/exec_stim.txt
# stall op instr pc a b c priv exc_ill exc_mis | result target jump wr_en rd_en strb addr ill wdata
# all hex, op is the op_e index, priv 3 is machine and 0 is user
0 1 13 100 5 7 0 3 0 0 c 100 0 1 0 0 c 0 0
0 2 13 100 5 7 0 3 0 0 fffffffe fffffffe 0 1 0 0 c 0 0
0 3 13 100 ffffffff 1 0 3 0 0 1 100 0 1 0 0 0 0 0
0 4 13 100 ffffffff 1 0 3 0 0 0 100 0 1 0 0 0 0 0
0 5 13 100 f0f0f0f0 ff00ff00 0 3 0 0 0ff00ff0 100 0 1 0 0 eff1eff0 0 0
0 6 13 100 f0f0f0f0 ff00ff00 0 3 0 0 fff0fff0 100 0 1 0 0 eff1eff0 0 0
0 7 13 100 f0f0f0f0 ff00ff00 0 3 0 0 f000f000 100 0 1 0 0 eff1eff0 0 0
0 8 13 100 1 4 0 3 1 1 10 100 0 1 0 0 4 1 0
0 9 13 100 80000000 4 0 3 0 0 08000000 100 0 1 0 0 80000004 0 0
0 a 13 100 80000000 4 0 3 0 0 f8000000 100 0 1 0 0 80000004 0 0
0 b 13 100 0 12345000 0 3 0 0 12345000 100 0 1 0 0 12345000 0 0
0 c 13 100 0 0 1000 3 0 0 1100 1100 0 1 0 0 0 0 1000
0 d 13 100 100 20 0 3 0 0 104 120 1 1 0 0 120 0 0
0 e 13 100 201 4 0 3 0 0 104 204 1 1 0 0 204 0 0
0 f 13 100 3 3 40 3 0 0 6 140 1 0 0 0 4 0 40
0 10 13 100 3 3 40 3 0 0 6 140 0 0 0 0 4 0 40
0 11 13 100 ffffffff 1 40 3 0 0 0 140 1 0 0 0 0 0 40
0 12 13 100 ffffffff 1 40 3 0 0 0 140 0 0 0 0 0 0 40
0 13 13 100 ffffffff 1 40 3 0 0 0 140 0 0 0 0 0 0 40
0 14 13 100 ffffffff 1 40 3 0 0 0 140 1 0 0 0 0 0 40
0 19 13 100 1000 8 0 3 0 0 1008 100 0 1 1 0 1008 0 0
0 15 13 100 1000 3 0 3 0 0 1003 100 0 1 1 0 1000 0 0
0 1a 13 100 1000 1 ab 3 0 0 1001 1ab 0 0 0 2 1000 0 abababab
0 1a 13 100 1000 3 ab 3 0 0 1003 1ab 0 0 0 8 1000 0 abababab
0 1b 13 100 1000 2 1234abcd 3 0 0 1002 1234accd 0 0 0 c 1000 0 abcdabcd
0 1c 13 100 1000 4 deadbeef 3 0 0 1004 deadbfef 0 0 0 f 1004 0 deadbeef
0 1d 340080f3 100 a5a5a5a5 0 0 3 0 0 0 100 0 1 0 0 a5a5a5a4 0 0
0 1e 340080f3 100 f 0 0 3 0 0 a5a5a5a5 100 0 1 0 0 c 0 0
0 1f 340080f3 100 a0 0 0 3 0 0 a5a5a5af 100 0 1 0 0 a0 0 0
0 20 340280f3 100 0 0 0 3 0 0 a5a5a50f 100 0 1 0 0 0 0 0
0 21 340900f3 100 0 0 0 3 0 0 5 100 0 1 0 0 0 0 0
0 22 340080f3 100 0 0 0 3 0 0 17 100 0 1 0 0 0 0 0
0 1e 340000f3 100 0 0 0 3 0 0 16 100 0 1 0 0 0 0 0
0 1e f14000f3 100 0 0 0 3 0 0 1 100 0 1 0 0 0 0 0
0 1d f14080f3 100 ff 0 0 3 0 0 0 100 0 1 0 0 fc 1 0
0 1d 340080f3 100 dead0000 0 0 0 0 0 0 100 0 1 0 0 dead0000 1 0
0 1e 340000f3 100 0 0 0 3 0 0 16 100 0 1 0 0 0 0 0
1 1d 340080f3 100 77777777 0 0 3 0 0 16 100 0 1 0 0 77777774 0 0
1 1 13 100 1 1 0 3 0 0 2 100 0 1 0 0 0 0 0
0 1e 340000f3 100 0 0 0 3 0 0 16 100 0 1 0 0 0 0 0

//--- exec_stage_top.f
design/exec_pkg.sv
design/exec_unit.sv
design/csr_bank.sv
design/exec_stage_top.sv
tb/exec_clk_gen.sv
tb/exec_stage_assertions.sv
tb/exec_stage_tb.sv

//--- Makefile
TB_TOP := exec_stage_tb

.PHONY: all run lint clean

all: run

run: obj_dir/V$(TB_TOP)
	@out="$$(./obj_dir/V$(TB_TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "Test completed successfully"

obj_dir/V$(TB_TOP): exec_stage_top.f design/*.sv tb/*.sv
	verilator --binary --timing --assert -f exec_stage_top.f --top-module $(TB_TOP)

lint:
	verilator --lint-only --timing --assert -f exec_stage_top.f --top-module $(TB_TOP)
	verilator --lint-only -Wall design/exec_pkg.sv design/exec_unit.sv design/csr_bank.sv \
		design/exec_stage_top.sv --top-module exec_stage_top

clean:
	rm -rf obj_dir
